// ==== source/exec_cfg.svh ====
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// datapath width
`define EXEC_XLEN 32

// register file, r0 reads as zero
`define EXEC_REGS 8
`define EXEC_RIDX 3 // log2 of EXEC_REGS

// immediate field of OP_LI, zero-extended
`define EXEC_IMMW 16

// one quotient bit per divider step
`define EXEC_DIV_STEPS 32

`endif

// ==== source/exec_isa_pkg.sv ====
`include "exec_cfg.svh"

package exec_isa_pkg;

	// execution opcodes
	typedef enum logic [3:0] {
		OP_ADD = 4'h0,
		OP_SUB = 4'h1,
		OP_AND = 4'h2,
		OP_OR  = 4'h3,
		OP_XOR = 4'h4,
		OP_SLL = 4'h5, // shift by rs2[4:0]
		OP_LI  = 4'h6, // rd = zero-extended imm
		OP_DIV = 4'h7, // unsigned quotient
		OP_REM = 4'h8  // unsigned remainder
	} opcode_e;

	// one issued instruction, 29 bits
	typedef struct packed {
		opcode_e                 op;
		logic [`EXEC_RIDX-1:0]   rd;
		logic [`EXEC_RIDX-1:0]   rs1;
		logic [`EXEC_RIDX-1:0]   rs2;
		logic [`EXEC_IMMW-1:0]   imm;
	} instr_t;

endpackage

// ==== source/exec_pipe_pkg.sv ====
`include "exec_cfg.svh"

package exec_pipe_pkg;

	// issue handshake states
	typedef enum logic [1:0] {
		ISS_IDLE,
		ISS_ACK,   // ack high, waiting for req to drop
		ISS_STALL  // req seen during a divide
	} issue_state_e;

	// record carried from stage to stage
	// a and b travel along so the divider in M2 sees the EX operands
	typedef struct packed {
		logic                   valid;
		exec_isa_pkg::opcode_e  op;
		logic [`EXEC_RIDX-1:0]  rd;
		logic [`EXEC_XLEN-1:0]  result;
		logic [`EXEC_XLEN-1:0]  a;
		logic [`EXEC_XLEN-1:0]  b;
	} stage_rec_t;

endpackage

// ==== source/exec_issue_if.sv ====
`include "exec_cfg.svh"

// accepted instruction from the issue FSM into EX
interface exec_issue_if import exec_isa_pkg::*; ();

	logic   valid; // one cycle per accepted instruction
	instr_t instr;
	logic   stall; // divide in flight, no new issue

	modport fsm (
		output valid,
		output instr,
		input  stall
	);

	modport pipe (
		input  valid,
		input  instr,
		output stall
	);

endinterface

// ==== source/issue_fsm.sv ====
`include "exec_cfg.svh"

module issue_fsm import exec_isa_pkg::*, exec_pipe_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   issue_req_i,
	input  opcode_e                issue_op_i,
	input  logic [`EXEC_RIDX-1:0]  issue_rd_i,
	input  logic [`EXEC_RIDX-1:0]  issue_rs1_i,
	input  logic [`EXEC_RIDX-1:0]  issue_rs2_i,
	input  logic [`EXEC_IMMW-1:0]  issue_imm_i,
	output logic                   issue_ack_o,
	exec_issue_if.fsm              iss
);

	issue_state_e state;
	logic         take; // accept at the coming edge

	// only accept when the instruction is sure to enter EX
	assign take = issue_req_i && !iss.stall &&
		(state == ISS_IDLE || state == ISS_STALL);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state       <= ISS_IDLE;
			issue_ack_o <= 1'b0;
			iss.valid   <= 1'b0;
		end else begin
			iss.valid <= take; // single-cycle pulse
			case (state)
				ISS_IDLE: begin
					if (take) begin
						state       <= ISS_ACK;
						issue_ack_o <= 1'b1;
					end else if (issue_req_i) begin
						state <= ISS_STALL; // divider busy
					end
				end
				ISS_STALL: begin
					if (take) begin
						state       <= ISS_ACK;
						issue_ack_o <= 1'b1;
					end
				end
				ISS_ACK: begin
					if (!issue_req_i) begin // host finished its half
						state       <= ISS_IDLE;
						issue_ack_o <= 1'b0;
					end
				end
				default: state <= ISS_IDLE;
			endcase
		end
	end

	// fields are stable while req is high
	always_ff @(posedge clk) begin
		if (take) begin
			iss.instr <= '{op: issue_op_i, rd: issue_rd_i, rs1: issue_rs1_i,
				rs2: issue_rs2_i, imm: issue_imm_i};
		end
	end

endmodule

// ==== source/div_step_counter.sv ====
`include "exec_cfg.svh"

module div_step_counter (
	input  logic clk,
	input  logic rst_n,
	input  logic start_i,
	output logic busy_o,
	output logic last_o
);

	localparam int CW = $clog2(`EXEC_DIV_STEPS + 1);

	logic [CW-1:0] cnt; // steps still to run

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (start_i) begin
			cnt <= CW'(`EXEC_DIV_STEPS);
		end else if (busy_o) begin
			cnt <= cnt - 1'b1;
		end
	end

	assign busy_o = (cnt != '0);
	assign last_o = (cnt == CW'(1)); // final step runs this cycle

endmodule

// ==== source/iter_divider.sv ====
`include "exec_cfg.svh"

module iter_divider (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  start_i,
	input  logic                  is_rem_i,
	input  logic [`EXEC_XLEN-1:0] dividend_i,
	input  logic [`EXEC_XLEN-1:0] divisor_i,
	output logic                  done_o,
	output logic [`EXEC_XLEN-1:0] result_o
);

	localparam int XL = `EXEC_XLEN;

	logic          busy;
	logic          last;
	logic          is_rem_q;
	logic [XL-1:0] rem_q;   // partial remainder
	logic [XL-1:0] quo_q;   // dividend shifting out, quotient shifting in
	logic [XL-1:0] dvs_q;
	logic [XL:0]   partial;
	logic [XL:0]   diff;
	logic [XL-1:0] rem_nxt;
	logic [XL-1:0] quo_nxt;

	div_step_counter u_steps (
		.clk     (clk),
		.rst_n   (rst_n),
		.start_i (start_i),
		.busy_o  (busy),
		.last_o  (last)
	);

	// one restoring step
	always_comb begin
		partial = {rem_q, quo_q[XL-1]};
		diff    = partial - {1'b0, dvs_q};
		if (!diff[XL]) begin
			rem_nxt = diff[XL-1:0];
			quo_nxt = {quo_q[XL-2:0], 1'b1};
		end else begin
			rem_nxt = partial[XL-1:0]; // restore
			quo_nxt = {quo_q[XL-2:0], 1'b0};
		end
	end

	// zero divisor never fails the trial, so all ones and the dividend fall out
	always_ff @(posedge clk) begin
		if (start_i) begin
			rem_q    <= '0;
			quo_q    <= dividend_i;
			dvs_q    <= divisor_i;
			is_rem_q <= is_rem_i;
		end else if (busy) begin
			rem_q <= rem_nxt;
			quo_q <= quo_nxt;
		end
		if (last) begin
			result_o <= is_rem_q ? rem_nxt : quo_nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			done_o <= 1'b0;
		end else begin
			done_o <= last;
		end
	end

endmodule

// ==== source/exec_pipeline.sv ====
`include "exec_cfg.svh"

module exec_pipeline import exec_isa_pkg::*, exec_pipe_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	exec_issue_if.pipe             iss,
	output logic                   wb_valid_o,
	output logic [`EXEC_RIDX-1:0]  wb_addr_o,
	output logic [`EXEC_XLEN-1:0]  wb_data_o
);

	localparam int XL = `EXEC_XLEN;
	localparam int SHW = $clog2(XL);

	logic [XL-1:0] regs [`EXEC_REGS];

	logic       ex_vld;
	instr_t     ex_ins;
	stage_rec_t ex_rec;
	stage_rec_t m1;
	stage_rec_t m2;
	stage_rec_t m2_fwd; // m2 with the divider result merged in
	stage_rec_t wb;

	logic [XL-1:0] op_a;
	logic [XL-1:0] op_b;

	logic          ex_div;
	logic          m1_div;
	logic          m2_div;
	logic          hold; // EX, M1 and M2 frozen
	logic          div_start;
	logic          div_run;
	logic          div_done;
	logic [XL-1:0] div_res;

	function automatic logic is_divop(input opcode_e op);
		return (op == OP_DIV) || (op == OP_REM);
	endfunction

	// youngest producer wins, register file last
	function automatic logic [XL-1:0] fwd(
		input logic [`EXEC_RIDX-1:0] idx,
		input stage_rec_t            s1,
		input stage_rec_t            s2,
		input stage_rec_t            s3,
		input logic [XL-1:0]         rf_val
	);
		if (idx == '0) return '0;
		if (s1.valid && s1.rd == idx) return s1.result;
		if (s2.valid && s2.rd == idx) return s2.result;
		if (s3.valid && s3.rd == idx) return s3.result;
		return rf_val;
	endfunction

	// EX operands and ALU
	always_comb begin
		op_a = fwd(ex_ins.rs1, m1, m2_fwd, wb, regs[ex_ins.rs1]);
		op_b = fwd(ex_ins.rs2, m1, m2_fwd, wb, regs[ex_ins.rs2]);

		ex_rec.valid = ex_vld;
		ex_rec.op    = ex_ins.op;
		ex_rec.rd    = ex_ins.rd;
		ex_rec.a     = op_a;
		ex_rec.b     = op_b;
		case (ex_ins.op)
			OP_ADD:  ex_rec.result = op_a + op_b;
			OP_SUB:  ex_rec.result = op_a - op_b;
			OP_AND:  ex_rec.result = op_a & op_b;
			OP_OR:   ex_rec.result = op_a | op_b;
			OP_XOR:  ex_rec.result = op_a ^ op_b;
			OP_SLL:  ex_rec.result = op_a << op_b[SHW-1:0];
			OP_LI:   ex_rec.result = XL'(ex_ins.imm);
			default: ex_rec.result = '0; // divides finish in M2
		endcase
	end

	// divide control
	assign ex_div    = ex_vld && is_divop(ex_ins.op);
	assign m1_div    = m1.valid && is_divop(m1.op);
	assign m2_div    = m2.valid && is_divop(m2.op);
	assign hold      = m2_div && !div_done;
	assign div_start = m2_div && !div_run && !div_done;

	// keeps issue closed until the divide result exists
	assign iss.stall = ex_div | m1_div | hold;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			div_run <= 1'b0;
		end else if (div_start) begin
			div_run <= 1'b1;
		end else if (div_done) begin
			div_run <= 1'b0;
		end
	end

	iter_divider u_div (
		.clk        (clk),
		.rst_n      (rst_n),
		.start_i    (div_start),
		.is_rem_i   (m2.op == OP_REM),
		.dividend_i (m2.a),
		.divisor_i  (m2.b),
		.done_o     (div_done),
		.result_o   (div_res)
	);

	always_comb begin
		m2_fwd = m2;
		if (m2_div) m2_fwd.result = div_res;
	end

	// stage registers
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_vld   <= 1'b0;
			m1.valid <= 1'b0;
			m2.valid <= 1'b0;
			wb.valid <= 1'b0;
		end else begin
			if (!hold) begin
				ex_vld <= iss.valid;
				m1     <= ex_rec;
				m2     <= m1;
			end
			wb       <= m2_fwd;
			wb.valid <= m2.valid && !hold && (m2.rd != '0); // bubble while held, r0 dropped
		end
	end

	always_ff @(posedge clk) begin
		if (!hold && iss.valid) ex_ins <= iss.instr;
	end

	// register file, written from WB
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `EXEC_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.valid) begin
			regs[wb.rd] <= wb.result;
		end
	end

	assign wb_valid_o = wb.valid;
	assign wb_addr_o  = wb.rd;
	assign wb_data_o  = wb.result;

endmodule

// ==== source/exec_core.sv ====
`include "exec_cfg.svh"

module exec_core import exec_isa_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   issue_req_i,
	input  opcode_e                issue_op_i,
	input  logic [`EXEC_RIDX-1:0]  issue_rd_i,
	input  logic [`EXEC_RIDX-1:0]  issue_rs1_i,
	input  logic [`EXEC_RIDX-1:0]  issue_rs2_i,
	input  logic [`EXEC_IMMW-1:0]  issue_imm_i,
	output logic                   issue_ack_o,
	output logic                   wb_valid_o,
	output logic [`EXEC_RIDX-1:0]  wb_addr_o,
	output logic [`EXEC_XLEN-1:0]  wb_data_o
);

	exec_issue_if iss_if ();

	// four-phase issue front end
	issue_fsm u_fsm (
		.clk         (clk),
		.rst_n       (rst_n),
		.issue_req_i (issue_req_i),
		.issue_op_i  (issue_op_i),
		.issue_rd_i  (issue_rd_i),
		.issue_rs1_i (issue_rs1_i),
		.issue_rs2_i (issue_rs2_i),
		.issue_imm_i (issue_imm_i),
		.issue_ack_o (issue_ack_o),
		.iss         (iss_if.fsm)
	);

	exec_pipeline u_pipe (
		.clk        (clk),
		.rst_n      (rst_n),
		.iss        (iss_if.pipe),
		.wb_valid_o (wb_valid_o),
		.wb_addr_o  (wb_addr_o),
		.wb_data_o  (wb_data_o)
	);

endmodule

// ==== verif/exec_core_checker.sv ====
`include "exec_cfg.svh"

module exec_core_checker (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  req_i,
	input logic                  ack_i,
	input logic                  wb_valid_i,
	input logic [`EXEC_RIDX-1:0] wb_addr_i,
	input logic                  iss_valid_i,
	input logic                  stall_i
);

	timeunit 1ns;
	timeprecision 100ps;

	// ack only answers a request
	ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(ack_i) |-> $past(req_i))
		else $error("issue ack rose without a request");

	ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(ack_i) |-> !$past(req_i))
		else $error("issue ack fell while the request was still high");

	wb_not_r0: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid_i |-> wb_addr_i != '0)
		else $error("writeback reported for r0");

	// accepted instruction must be able to enter EX
	accept_no_stall: assert property (@(posedge clk) disable iff (!rst_n)
		iss_valid_i |-> !stall_i)
		else $error("instruction accepted while the pipeline is stalled");

endmodule

// ==== verif/exec_core_tb.sv ====
`include "exec_cfg.svh"

module exec_core_tb import exec_isa_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int XL = `EXEC_XLEN;
	localparam int RW = `EXEC_RIDX;
	localparam int IW = `EXEC_IMMW;

	logic          clk;
	logic          rst_n;
	logic          issue_req;
	opcode_e       issue_op;
	logic [RW-1:0] issue_rd;
	logic [RW-1:0] issue_rs1;
	logic [RW-1:0] issue_rs2;
	logic [IW-1:0] issue_imm;
	logic          issue_ack;
	logic          wb_valid;
	logic [RW-1:0] wb_addr;
	logic [XL-1:0] wb_data;

	// tests as read from the stimulus file
	string         t_name [$];
	logic [3:0]    t_op   [$];
	logic [RW-1:0] t_rd   [$];
	logic [RW-1:0] t_rs1  [$];
	logic [RW-1:0] t_rs2  [$];
	logic [IW-1:0] t_imm  [$];
	logic [XL-1:0] t_exp  [$];

	// writebacks still owed, in issue order
	string         exp_name [$];
	logic [RW-1:0] exp_rd   [$];
	logic [XL-1:0] exp_val  [$];

	int errors;
	int n_pass;
	int n_wb;
	int wd_limit;
	bit armed; // watchdog starts once the test count is known

	exec_core UUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.issue_req_i (issue_req),
		.issue_op_i  (issue_op),
		.issue_rd_i  (issue_rd),
		.issue_rs1_i (issue_rs1),
		.issue_rs2_i (issue_rs2),
		.issue_imm_i (issue_imm),
		.issue_ack_o (issue_ack),
		.wb_valid_o  (wb_valid),
		.wb_addr_o   (wb_addr),
		.wb_data_o   (wb_data)
	);

	bind exec_core exec_core_checker u_chk (
		.clk         (clk),
		.rst_n       (rst_n),
		.req_i       (issue_req_i),
		.ack_i       (issue_ack_o),
		.wb_valid_i  (wb_valid_o),
		.wb_addr_i   (wb_addr_o),
		.iss_valid_i (iss_if.valid),
		.stall_i     (iss_if.stall)
	);

	always #4 clk = ~clk;

	task automatic load_stimulus(output bit ok);
		int            fd;
		int            cnt;
		int            rd_v;
		int            rs1_v;
		int            rs2_v;
		logic [31:0]   op_v;
		logic [31:0]   imm_v;
		logic [XL-1:0] exp_v;
		string         line;
		string         name;
		ok = 1'b0;
		fd = $fopen("verif/exec_stimulus.txt", "r");
		if (fd == 0) return;
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.substr(0, 0) == "#") continue; // blank or comment
			cnt = $sscanf(line, "%s %h %d %d %d %h %h", name, op_v, rd_v, rs1_v, rs2_v,
				imm_v, exp_v);
			if (cnt != 7) begin
				errors++;
				$display("stimulus line could not be parsed: %s", line);
				continue;
			end
			t_name.push_back(name);
			t_op.push_back(op_v[3:0]);
			t_rd.push_back(rd_v[RW-1:0]);
			t_rs1.push_back(rs1_v[RW-1:0]);
			t_rs2.push_back(rs2_v[RW-1:0]);
			t_imm.push_back(imm_v[IW-1:0]);
			t_exp.push_back(exp_v);
		end
		$fclose(fd);
		ok = (t_name.size() > 0);
	endtask

	// full four-phase cycle for test i
	task automatic issue_one(input int i);
		@(negedge clk);
		issue_op  = opcode_e'(t_op[i]);
		issue_rd  = t_rd[i];
		issue_rs1 = t_rs1[i];
		issue_rs2 = t_rs2[i];
		issue_imm = t_imm[i];
		issue_req = 1'b1;
		if (t_rd[i] != '0) begin
			exp_name.push_back(t_name[i]);
			exp_rd.push_back(t_rd[i]);
			exp_val.push_back(t_exp[i]);
		end else begin
			$display("test %s: r0 target, no writeback expected", t_name[i]);
		end
		do @(negedge clk); while (issue_ack !== 1'b1);
		issue_req = 1'b0;
		do @(negedge clk); while (issue_ack !== 1'b0);
	endtask

	task automatic check_writeback(input string name, input logic [RW-1:0] rd,
		input logic [XL-1:0] val);
		if (wb_addr !== rd || wb_data !== val) begin
			errors++;
			$display("Mismatch in %s: expected r%0d = %h, actual r%0d = %h",
				name, rd, val, wb_addr, wb_data);
		end else begin
			n_pass++;
			$display("test %s: ok, r%0d = %h", name, wb_addr, wb_data);
		end
	endtask

	task automatic drain_writebacks();
		int n;
		n = 0;
		while (exp_rd.size() != 0 && n < 200) begin
			@(negedge clk);
			n++;
		end
		repeat (10) @(negedge clk); // room for any stray writeback
		if (exp_rd.size() != 0) begin
			errors++;
			$display("%0d expected writebacks never arrived", exp_rd.size());
		end
	endtask

	// outputs settle after the rising edge, so look at them on the falling one
	always @(negedge clk) begin
		if (rst_n && wb_valid) begin
			n_wb++;
			if (exp_rd.size() == 0) begin
				errors++;
				$display("writeback to r%0d with no instruction outstanding", wb_addr);
			end else begin
				check_writeback(exp_name.pop_front(), exp_rd.pop_front(), exp_val.pop_front());
			end
		end
	end

	initial begin
		wait (armed);
		repeat (wd_limit) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles", wd_limit);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		bit ok;
		clk       = 1'b0;
		rst_n     = 1'b0;
		issue_req = 1'b0;
		issue_op  = OP_ADD;
		issue_rd  = '0;
		issue_rs1 = '0;
		issue_rs2 = '0;
		issue_imm = '0;
		load_stimulus(ok);
		if (!ok) begin
			errors++;
			$display("could not read any test from the stimulus file");
		end else begin
			wd_limit = t_name.size() * 50 + 100;
			armed    = 1'b1;
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		if (ok) begin
			@(negedge clk);
			if (issue_ack !== 1'b0 || wb_valid !== 1'b0) begin
				errors++;
				$display("issue ack or writeback valid is high right after reset");
			end else begin
				$display("test reset_state: ok");
			end
			for (int i = 0; i < t_name.size(); i++) begin
				issue_one(i);
			end
			drain_writebacks();
		end
		$display("tests %0d, writebacks %0d, passed %0d, errors %0d",
			t_name.size(), n_wb, n_pass, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== verif/exec_stimulus.txt ====
# name  opcode(hex: 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 li 7 div 8 rem)  rd rs1 rs2  imm(hex)  expected(hex)
# a line with rd 0 expects no writeback, its expected column is ignored
reset_read    0 3 5 6 0000 00000000
li_r1         6 1 0 0 1234 00001234
li_r2         6 2 0 0 00ff 000000ff
add           0 3 1 2 0000 00001333
sub           1 4 2 1 0000 ffffeecb
and           2 5 1 2 0000 00000034
or            3 5 1 2 0000 000012ff
xor           4 6 1 2 0000 000012cb
li_shamt      6 7 0 0 0024 00000024
sll           5 6 1 7 0000 00012340
chain_li      6 3 0 0 0005 00000005
chain_add     0 3 3 3 0000 0000000a
chain_sll     5 4 3 3 0000 00002800
chain_sub     1 5 4 3 0000 000027f6
chain_xor     4 6 5 4 0000 00000ff6
div_li_a      6 1 0 0 03e8 000003e8
div_li_b      6 2 0 0 0007 00000007
div           7 3 1 2 0000 0000008e
rem           8 4 1 2 0000 00000006
div_zero      7 5 1 0 0000 ffffffff
rem_zero      8 6 1 0 0000 000003e8
div_chain     7 7 3 2 0000 00000014
after_div_add 0 1 7 7 0000 00000028
after_div_or  3 2 7 4 0000 00000016
r0_li         6 0 0 0 beef 00000000
r0_read       0 3 0 1 0000 00000028
r0_sub        1 0 1 2 0000 00000000
r0_or         3 4 0 0 0000 00000000

// ==== exec_core.f ====
+incdir+source
source/exec_isa_pkg.sv
source/exec_pipe_pkg.sv
source/exec_issue_if.sv
source/issue_fsm.sv
source/div_step_counter.sv
source/iter_divider.sv
source/exec_pipeline.sv
source/exec_core.sv
verif/exec_core_checker.sv
verif/exec_core_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = exec_core_tb
FLIST     = exec_core.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); test $$rc -eq 0
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
